/* verilog/mips_pkg.sv */
package mips_pkg;

    // datapath widths
    localparam int NB_DATA   = 32;
    localparam int NB_ADDR   = 8;  // word address into data RAM
    localparam int NB_REG    = 5;
    localparam int RAM_DEPTH = 256;
    localparam int REG_COUNT = 32;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4   // signed compare giving 0 or 1
    } alu_op_t;

    // access width with the same code points as the load/store funct bits
    typedef enum logic [1:0] {
        W_BYTE = 2'b00,
        W_HALF = 2'b01,
        W_WORD = 2'b10,
        W_NONE = 2'b11
    } mem_width_t;

    // request into the execute stage
    typedef struct packed {
        logic               valid;
        alu_op_t            alu_op;
        logic [NB_DATA-1:0] operand_a;
        logic [NB_DATA-1:0] operand_b;
        logic [NB_DATA-1:0] store_data;
        logic [NB_REG-1:0]  rd;
        mem_width_t         width;
        logic               sign_flag;  // 1 sign extends, 0 zero extends
        logic               mem_write;
        logic               reg_write;
        logic               mem2reg;    // 1 picks load data at write-back
    } ex_req_t;

    typedef struct packed {
        logic               valid;
        logic [NB_DATA-1:0] result;
        logic [NB_DATA-1:0] store_data;
        logic [NB_REG-1:0]  rd;
        mem_width_t         width;
        logic               sign_flag;
        logic               mem_write;
        logic               reg_write;
        logic               mem2reg;
    } ex_mem_t;

    typedef struct packed {
        logic               valid;
        logic [NB_DATA-1:0] load_data;
        logic [NB_DATA-1:0] alu_result;
        logic [NB_REG-1:0]  rd;
        logic               reg_write;
        logic               mem2reg;
    } mem_wb_t;

    // width extension shared by store shaping and load extension
    function automatic logic [NB_DATA-1:0] extend_by_width(
        input logic [NB_DATA-1:0] value,
        input mem_width_t         width,
        input logic               sign_flag
    );
        logic [NB_DATA-1:0] ext;
        case (width)
            W_BYTE: ext = sign_flag ? {{24{value[7]}}, value[7:0]} : {24'b0, value[7:0]};
            W_HALF: ext = sign_flag ? {{16{value[15]}}, value[15:0]} : {16'b0, value[15:0]};
            W_WORD: ext = value;
            default: ext = '0;  // W_NONE
        endcase
        return ext;
    endfunction

endpackage

/* verilog/data_ram.sv */
module data_ram (
    input  logic                         clk,
    input  logic                         i_we,
    input  logic [mips_pkg::NB_ADDR-1:0] i_addr,
    input  logic [mips_pkg::NB_DATA-1:0] i_data,
    output logic [mips_pkg::NB_DATA-1:0] o_data
);
    import mips_pkg::*;

    // word array with contents undefined until written
    logic [NB_DATA-1:0] mem [RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_data;
        end
    end

    // async read sees the old word during a same-cycle write
    assign o_data = mem[i_addr];

endmodule

/* verilog/execute_stage.sv */
module execute_stage (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_halt,
    input  mips_pkg::ex_req_t i_req,
    output mips_pkg::ex_mem_t o_ex_mem
);
    import mips_pkg::*;

    logic [NB_DATA-1:0] alu_result;
    ex_mem_t            ex_mem_d;
    ex_mem_t            ex_mem_q;

    // alu
    always_comb begin
        case (i_req.alu_op)
            ALU_ADD: alu_result = i_req.operand_a + i_req.operand_b;
            ALU_SUB: alu_result = i_req.operand_a - i_req.operand_b;
            ALU_AND: alu_result = i_req.operand_a & i_req.operand_b;
            ALU_OR:  alu_result = i_req.operand_a | i_req.operand_b;
            ALU_SLT: begin
                // signed less-than
                alu_result = ($signed(i_req.operand_a) < $signed(i_req.operand_b)) ?
                             {{(NB_DATA-1){1'b0}}, 1'b1} : '0;
            end
            default: alu_result = '0;
        endcase
    end

    // next EX/MEM bundle
    always_comb begin
        ex_mem_d.valid      = i_req.valid;
        ex_mem_d.result     = alu_result;
        ex_mem_d.store_data = i_req.store_data;
        ex_mem_d.rd         = i_req.rd;
        ex_mem_d.width      = i_req.width;
        ex_mem_d.sign_flag  = i_req.sign_flag;
        ex_mem_d.mem2reg    = i_req.mem2reg;
        // an idle slot must not write anything downstream
        ex_mem_d.mem_write  = i_req.valid & i_req.mem_write;
        ex_mem_d.reg_write  = i_req.valid & i_req.reg_write;
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ex_mem_q <= '0;
        end else if (!i_halt) begin
            ex_mem_q <= ex_mem_d;  // hold while halted
        end
    end

    assign o_ex_mem = ex_mem_q;

endmodule

/* verilog/memory_stage.sv */
module memory_stage (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_halt,
    input  mips_pkg::ex_mem_t i_ex_mem,
    output mips_pkg::mem_wb_t o_mem_wb
);
    import mips_pkg::*;

    logic [NB_ADDR-1:0] ram_addr;
    logic [NB_DATA-1:0] ram_wdata;
    logic [NB_DATA-1:0] ram_rdata;
    logic               ram_we;
    logic [NB_DATA-1:0] load_ext;
    mem_wb_t            mem_wb_d;
    mem_wb_t            mem_wb_q;

    assign ram_addr = i_ex_mem.result[NB_ADDR-1:0];  // word address with the upper bits ignored

    // sub-word stores overwrite the full word with the extended value
    assign ram_wdata = extend_by_width(i_ex_mem.store_data, i_ex_mem.width,
                                       i_ex_mem.sign_flag);

    assign ram_we = i_ex_mem.valid & i_ex_mem.mem_write & ~i_halt;

    data_ram u_data_ram (
        .clk    (clk),
        .i_we   (ram_we),
        .i_addr (ram_addr),
        .i_data (ram_wdata),
        .o_data (ram_rdata)
    );

    // load path uses the same width rule
    assign load_ext = extend_by_width(ram_rdata, i_ex_mem.width, i_ex_mem.sign_flag);

    always_comb begin
        mem_wb_d.valid      = i_ex_mem.valid;
        mem_wb_d.load_data  = load_ext;
        mem_wb_d.alu_result = i_ex_mem.result;
        mem_wb_d.rd         = i_ex_mem.rd;
        mem_wb_d.reg_write  = i_ex_mem.reg_write;
        mem_wb_d.mem2reg    = i_ex_mem.mem2reg;
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mem_wb_q <= '0;
        end else if (!i_halt) begin
            mem_wb_q <= mem_wb_d;
        end
    end

    assign o_mem_wb = mem_wb_q;

endmodule

/* verilog/register_file.sv */
module register_file (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic                         i_halt,
    input  mips_pkg::mem_wb_t            i_mem_wb,
    input  logic [mips_pkg::NB_REG-1:0]  i_dbg_addr,
    output logic [mips_pkg::NB_DATA-1:0] o_dbg_data
);
    import mips_pkg::*;

    logic [NB_DATA-1:0] regs [REG_COUNT];
    logic [NB_DATA-1:0] wb_data;
    logic               wb_en;

    // write-back select
    assign wb_data = i_mem_wb.mem2reg ? i_mem_wb.load_data : i_mem_wb.alu_result;

    // r0 is never written so it stays at its reset value of 0
    assign wb_en = i_mem_wb.valid & i_mem_wb.reg_write & ~i_halt &
                   (i_mem_wb.rd != '0);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[i_mem_wb.rd] <= wb_data;
        end
    end

    assign o_dbg_data = regs[i_dbg_addr];  // combinational debug read

endmodule

/* verilog/mem_subsystem.sv */
module mem_subsystem (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic                         i_halt,
    input  mips_pkg::ex_req_t            i_req,
    input  logic [mips_pkg::NB_REG-1:0]  i_dbg_addr,
    output logic [mips_pkg::NB_DATA-1:0] o_dbg_data,
    output mips_pkg::mem_wb_t            o_mem_wb
);
    import mips_pkg::*;

    ex_mem_t ex_mem;  // execute -> memory
    mem_wb_t mem_wb;  // memory -> write-back

    execute_stage u_execute_stage (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_halt   (i_halt),
        .i_req    (i_req),
        .o_ex_mem (ex_mem)
    );

    memory_stage u_memory_stage (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_halt   (i_halt),
        .i_ex_mem (ex_mem),
        .o_mem_wb (mem_wb)
    );

    // write-back and debug observation
    register_file u_register_file (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_halt     (i_halt),
        .i_mem_wb   (mem_wb),
        .i_dbg_addr (i_dbg_addr),
        .o_dbg_data (o_dbg_data)
    );

    // MEM/WB bundle made visible for load checks
    assign o_mem_wb = mem_wb;

endmodule

/* tests/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int NUM_VEC = 48;

// entry i is driven in cycle i and its checks look at that same cycle
typedef struct packed {
    ex_req_t            req;
    logic               halt;
    logic               chk_reg;   // compare debug port with reg_exp
    logic [NB_REG-1:0]  reg_idx;
    logic [NB_DATA-1:0] reg_exp;
    logic               chk_load;  // compare o_mem_wb.load_data
    logic [NB_DATA-1:0] load_exp;
    logic               chk_hold;  // MEM/WB equal to previous cycle
} vec_t;

vec_t vectors [NUM_VEC];

task automatic alu_entry(input int idx, input alu_op_t op, input logic [NB_DATA-1:0] a,
                         input logic [NB_DATA-1:0] b, input logic [NB_REG-1:0] rd);
    vectors[idx].req.valid     = 1'b1;
    vectors[idx].req.alu_op    = op;
    vectors[idx].req.operand_a = a;
    vectors[idx].req.operand_b = b;
    vectors[idx].req.rd        = rd;
    vectors[idx].req.width     = W_WORD;
    vectors[idx].req.reg_write = 1'b1;
endtask

// address goes through the alu as addr + 0
task automatic store_entry(input int idx, input logic [NB_ADDR-1:0] addr,
                           input logic [NB_DATA-1:0] data, input mem_width_t w, input logic s);
    vectors[idx].req.valid      = 1'b1;
    vectors[idx].req.alu_op     = ALU_ADD;
    vectors[idx].req.operand_a  = {{(NB_DATA-NB_ADDR){1'b0}}, addr};
    vectors[idx].req.store_data = data;
    vectors[idx].req.width      = w;
    vectors[idx].req.sign_flag  = s;
    vectors[idx].req.mem_write  = 1'b1;
endtask

task automatic load_entry(input int idx, input logic [NB_ADDR-1:0] addr,
                          input logic [NB_REG-1:0] rd, input mem_width_t w, input logic s);
    vectors[idx].req.valid     = 1'b1;
    vectors[idx].req.alu_op    = ALU_ADD;
    vectors[idx].req.operand_a = {{(NB_DATA-NB_ADDR){1'b0}}, addr};
    vectors[idx].req.rd        = rd;
    vectors[idx].req.width     = w;
    vectors[idx].req.sign_flag = s;
    vectors[idx].req.reg_write = 1'b1;
    vectors[idx].req.mem2reg   = 1'b1;
endtask

task automatic expect_reg(input int idx, input logic [NB_REG-1:0] r,
                          input logic [NB_DATA-1:0] v);
    vectors[idx].chk_reg = 1'b1;
    vectors[idx].reg_idx = r;
    vectors[idx].reg_exp = v;
endtask

task automatic expect_load(input int idx, input logic [NB_DATA-1:0] v);
    vectors[idx].chk_load = 1'b1;
    vectors[idx].load_exp = v;
endtask

task automatic build_vectors();
    logic [NB_DATA-1:0] a;
    logic [NB_DATA-1:0] b;
    logic [NB_DATA-1:0] w20;
    logic [NB_DATA-1:0] w21;
    logic [NB_DATA-1:0] rnd;
    mem_width_t         w;
    logic [NB_ADDR-1:0] addr;
    int                 st;
    for (int i = 0; i < NUM_VEC; i++) vectors[i] = '0;  // bubbles without checks
    // alu results reach the debug port 3 edges later
    for (int n = 0; n < 5; n++) begin
        a = $random(seed);
        b = $random(seed);
        alu_entry(n, alu_op_t'(n), a, b, 5'd1 + n[4:0]);
        expect_reg(n + 3, 5'd1 + n[4:0], alu_ref(alu_op_t'(n), a, b));
    end
    alu_entry(5, ALU_ADD, 32'h1234, 32'h1, 5'd0);
    expect_reg(8, 5'd0, 32'h0);
    alu_entry(6, ALU_SLT, 32'hffff_fffb, 32'h3, 5'd6);
    expect_reg(9, 5'd6, alu_ref(ALU_SLT, 32'hffff_fffb, 32'h3));
    alu_entry(7, ALU_SLT, 32'h3, 32'hffff_fffb, 5'd13);
    expect_reg(10, 5'd13, alu_ref(ALU_SLT, 32'h3, 32'hffff_fffb));
    // word store then back-to-back load
    a = $random(seed);
    store_entry(8, 8'h10, a, W_WORD, 1'b0);
    load_entry(9, 8'h10, 5'd7, W_WORD, 1'b0);
    expect_load(11, a);
    expect_reg(12, 5'd7, a);
    // byte and half loads from known words
    w20 = 32'h1234_80f6;
    w21 = $random(seed);
    store_entry(10, 8'h20, w20, W_WORD, 1'b0);
    store_entry(11, 8'h21, w21, W_WORD, 1'b0);
    load_entry(12, 8'h20, 5'd14, W_BYTE, 1'b1);
    expect_load(14, extend_ref(w20, W_BYTE, 1'b1));
    expect_reg(15, 5'd14, 32'hffff_fff6);
    load_entry(13, 8'h20, 5'd15, W_BYTE, 1'b0);
    expect_load(15, extend_ref(w20, W_BYTE, 1'b0));
    expect_reg(16, 5'd15, 32'h0000_00f6);
    load_entry(14, 8'h20, 5'd16, W_HALF, 1'b1);
    expect_load(16, extend_ref(w20, W_HALF, 1'b1));
    expect_reg(17, 5'd16, 32'hffff_80f6);
    load_entry(15, 8'h20, 5'd17, W_HALF, 1'b0);
    expect_load(17, extend_ref(w20, W_HALF, 1'b0));
    expect_reg(18, 5'd17, 32'h0000_80f6);
    load_entry(16, 8'h21, 5'd18, W_BYTE, 1'b1);
    expect_load(18, extend_ref(w21, W_BYTE, 1'b1));
    expect_reg(19, 5'd18, extend_ref(w21, W_BYTE, 1'b1));
    load_entry(17, 8'h21, 5'd19, W_HALF, 1'b1);
    expect_load(19, extend_ref(w21, W_HALF, 1'b1));
    expect_reg(20, 5'd19, extend_ref(w21, W_HALF, 1'b1));
    // sub-word stores fill the whole word
    rnd = $random(seed);
    store_entry(18, 8'h30, 32'habcd_1285, W_BYTE, 1'b1);
    store_entry(19, 8'h31, 32'h1357_9bdf, W_HALF, 1'b0);
    store_entry(20, 8'h32, rnd, W_NONE, 1'b1);
    load_entry(21, 8'h30, 5'd20, W_WORD, 1'b0);
    expect_load(23, extend_ref(32'habcd_1285, W_BYTE, 1'b1));
    expect_reg(24, 5'd20, 32'hffff_ff85);
    load_entry(22, 8'h31, 5'd21, W_WORD, 1'b0);
    expect_load(24, extend_ref(32'h1357_9bdf, W_HALF, 1'b0));
    expect_reg(25, 5'd21, 32'h0000_9bdf);
    load_entry(23, 8'h32, 5'd22, W_WORD, 1'b0);
    expect_load(25, extend_ref(rnd, W_NONE, 1'b1));
    expect_reg(26, 5'd22, 32'h0);
    // halt in cycles 28 and 29 drops the request issued at 28
    store_entry(24, 8'h40, 32'h1111_1111, W_WORD, 1'b0);
    load_entry(26, 8'h20, 5'd12, W_WORD, 1'b0);
    alu_entry(27, ALU_ADD, 32'h99, 32'h0, 5'd9);
    store_entry(28, 8'h40, 32'h2222_2222, W_WORD, 1'b0);
    vectors[28].req.reg_write = 1'b1;
    vectors[28].req.rd        = 5'd10;
    vectors[28].halt          = 1'b1;
    vectors[29].halt          = 1'b1;
    expect_load(28, w20);
    vectors[29].chk_hold = 1'b1;
    expect_reg(29, 5'd12, 32'h0);
    vectors[30].chk_hold = 1'b1;
    expect_reg(30, 5'd12, 32'h0);
    load_entry(31, 8'h40, 5'd11, W_WORD, 1'b0);
    expect_reg(31, 5'd12, w20);  // held bundle written once halt drops
    expect_reg(32, 5'd9, 32'h99);
    expect_load(33, 32'h1111_1111);
    expect_reg(33, 5'd10, 32'h0);
    expect_reg(34, 5'd11, 32'h1111_1111);
    // random width stores read back as words
    for (int k = 0; k < 4; k++) begin
        st   = 35 + 2 * k;
        rnd  = $random(seed);
        a    = $random(seed);
        w    = mem_width_t'(rnd[7:6]);
        addr = {2'b10, rnd[5:0]};
        store_entry(st, addr, a, w, rnd[8]);
        load_entry(st + 1, addr, 5'd23 + k[4:0], W_WORD, 1'b0);
        expect_load(st + 3, extend_ref(a, w, rnd[8]));
        expect_reg(st + 4, 5'd23 + k[4:0], extend_ref(a, w, rnd[8]));
    end
endtask

`endif

/* tests/tb_mem_subsystem.sv */
module tb_mem_subsystem;
    import mips_pkg::*;

    localparam int CLK_HALF      = 5;
    localparam int RESET_CYCLES  = 16;
    localparam int DRAIN_TIMEOUT = 20;

    logic               clk;
    logic               i_rst_n;
    logic               i_halt;
    ex_req_t            i_req;
    logic [NB_REG-1:0]  i_dbg_addr;
    logic [NB_DATA-1:0] o_dbg_data;
    mem_wb_t            o_mem_wb;

    mem_wb_t mem_wb_prev;  // last cycle's MEM/WB for the halt checks
    integer  seed;
    int      check_count;

    mem_subsystem dut0 (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_halt     (i_halt),
        .i_req      (i_req),
        .i_dbg_addr (i_dbg_addr),
        .o_dbg_data (o_dbg_data),
        .o_mem_wb   (o_mem_wb)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // reference alu with the signed compare done through the sign bits
    function automatic logic [NB_DATA-1:0] alu_ref(
        input alu_op_t            op,
        input logic [NB_DATA-1:0] a,
        input logic [NB_DATA-1:0] b
    );
        logic [NB_DATA-1:0] r;
        r = '0;
        case (op)
            ALU_ADD: r = a + b;
            ALU_SUB: r = a - b;
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_SLT: begin
                if (a[NB_DATA-1] != b[NB_DATA-1]) begin
                    r = {31'h0, a[NB_DATA-1]};  // negative side is the smaller one
                end else begin
                    r = {31'h0, (a < b)};
                end
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    // byte and half are masked first, then the sign fill is or-ed in
    function automatic logic [NB_DATA-1:0] extend_ref(
        input logic [NB_DATA-1:0] raw,
        input mem_width_t         w,
        input logic               sgn
    );
        logic [NB_DATA-1:0] v;
        v = '0;
        if (w == W_WORD) begin
            v = raw;
        end else if (w == W_BYTE) begin
            v = raw & 32'h0000_00ff;
            if (sgn && raw[7]) v = v | 32'hffff_ff00;
        end else if (w == W_HALF) begin
            v = raw & 32'h0000_ffff;
            if (sgn && raw[15]) v = v | 32'hffff_0000;
        end
        return v;  // code 3 stays zero
    endfunction

    task automatic fail_run(input string msg);
        $display("ERR t=%0t %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    `include "tb_vectors.svh"

    task automatic drive_entry(input vec_t v);
        i_req      = v.req;
        i_halt     = v.halt;
        i_dbg_addr = v.chk_reg ? v.reg_idx : '0;
    endtask

    task automatic check_entry(input int idx);
        vec_t v;
        v = vectors[idx];
        if (v.chk_load) begin
            check_count++;
            assert (o_mem_wb.valid && o_mem_wb.load_data === v.load_exp) else
                fail_run($sformatf("entry %0d load_data %h valid %b, expected %h",
                                   idx, o_mem_wb.load_data, o_mem_wb.valid, v.load_exp));
        end
        if (v.chk_reg) begin
            check_count++;
            assert (o_dbg_data === v.reg_exp) else
                fail_run($sformatf("entry %0d r%0d reads %h, expected %h",
                                   idx, v.reg_idx, o_dbg_data, v.reg_exp));
        end
        if (v.chk_hold) begin
            check_count++;
            assert (o_mem_wb === mem_wb_prev) else
                fail_run($sformatf("entry %0d MEM/WB moved during halt: %h, held %h",
                                   idx, o_mem_wb, mem_wb_prev));
        end
    endtask

    task automatic check_reset_state();
        check_count++;
        assert (!o_mem_wb.valid && !o_mem_wb.reg_write && !o_mem_wb.mem2reg) else
            fail_run($sformatf("MEM/WB controls after reset v=%b rw=%b m2r=%b",
                               o_mem_wb.valid, o_mem_wb.reg_write, o_mem_wb.mem2reg));
        for (int r = 0; r < REG_COUNT; r++) begin
            i_dbg_addr = r[NB_REG-1:0];
            #1;
            check_count++;
            assert (o_dbg_data === '0) else
                fail_run($sformatf("r%0d reads %h after reset", r, o_dbg_data));
        end
        i_dbg_addr = '0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (o_mem_wb.valid && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #5;
            cycles++;
        end
        if (o_mem_wb.valid) begin
            $display("timeout: MEM/WB still valid %0d cycles after the table", DRAIN_TIMEOUT);
            $display("Simulation FAILED");
            $fatal(1, "pipeline did not drain");
        end
    endtask

    initial begin
        i_rst_n     = 1'b0;
        i_halt      = 1'b0;
        i_req       = '0;
        i_dbg_addr  = '0;
        mem_wb_prev = '0;
        check_count = 0;
        seed        = 32'h6cfb;
        build_vectors();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        i_rst_n = 1'b1;
        check_reset_state();
        // one entry per cycle with checks mid-cycle where outputs are settled
        for (int i = 0; i < NUM_VEC; i++) begin
            @(posedge clk);
            #1;
            drive_entry(vectors[i]);
            #4;
            check_entry(i);
            mem_wb_prev = o_mem_wb;
        end
        @(posedge clk);
        #1;
        i_req  = '0;
        i_halt = 1'b0;
        wait_drain();
        $display("%0d checks done", check_count);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+tests
verilog/mips_pkg.sv
verilog/data_ram.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/register_file.sv
verilog/mem_subsystem.sv
tests/tb_mem_subsystem.sv

/* Makefile */
# Verilator flow for the memory-stage pipeline

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= tb_mem_subsystem
RTL_TOP   ?= mem_subsystem
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation PASSED

SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)
SOURCES := $(wildcard verilog/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

# the log decides the result, the binary status alone is not trusted
sim: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "sim: pass message found in $(LOG)"; \
	else \
		echo "sim: pass message missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
